//--- hw/cpuDefs_defs.svh
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

////////////////////////////////////////
// ISA sizes
////////////////////////////////////////

// Data word and PC width
`define WORD_W 16

// Architectural registers
`define NUM_REGS 16

// Bits needed to address one register
`define REG_AW 4

// Opcode field in bits 15:12 of the instruction
`define OP_W 4

`endif

//--- hw/isaPkg.sv
`include "cpuDefs_defs.svh"

package isaPkg;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  typedef enum logic [`OP_W-1:0] {
    ADD    = 4'h0,  // Compute group
    SUB    = 4'h1,
    XOR    = 4'h2,
    RED    = 4'h3,
    SLL    = 4'h4,  // Shift and rotate group
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,
    LW     = 4'h8,  // Memory group
    SW     = 4'h9,
    LLB    = 4'hA,  // Byte loads into rd
    LHB    = 4'hB,
    B      = 4'hC,  // PC relative branch
    BR     = 4'hD,  // Branch to register
    PCS    = 4'hE,
    HLT    = 4'hF
  } opcode_e;

  // Branch condition in bits 11:9
  typedef enum logic [2:0] {
    NEQ    = 3'd0,
    EQ     = 3'd1,
    GT     = 3'd2,
    LT     = 3'd3,
    GTE    = 3'd4,
    LTE    = 3'd5,
    OVFL   = 3'd6,
    UNCOND = 3'd7
  } condCode_e;

  // Positions in the 3-bit flags word
  localparam int unsigned flagZ = 2;
  localparam int unsigned flagV = 1;
  localparam int unsigned flagN = 0;

endpackage

//--- hw/pipePkg.sv
`include "cpuDefs_defs.svh"

package pipePkg;
  import isaPkg::*;

  // Control unit output for one instruction
  typedef struct packed {
    opcode_e aluOp;    // ALU function select
    logic    aluSrc;   // Immediate as second ALU operand
    logic    regSrc;   // LLB/LHB read rd as source 1
    logic    zEn;      // Update Z
    logic    nvEn;     // Update N and V
    logic    memEnable;
    logic    memWrite;
    logic    regWrite;
    logic    memToReg; // Load data goes to rd
    logic    hlt;
    logic    pcs;
    logic    branch;   // B or BR
  } ctrlWord_t;

  ////////////////////////////////////////
  // Bundles handed to later stages
  ////////////////////////////////////////
  typedef struct packed {
    logic [`REG_AW-1:0] srcReg1;   // For forwarding checks
    logic [`REG_AW-1:0] srcReg2;
    logic [`WORD_W-1:0] aluIn1;
    logic [`WORD_W-1:0] aluImm;
    logic [`WORD_W-1:0] aluIn2;
    opcode_e            aluOp;
    logic               aluSrc;
    logic               zEn;
    logic               nvEn;
  } exStage_t;

  typedef struct packed {
    logic [`WORD_W-1:0] memWriteData;  // Store data from rd
    logic               memEnable;
    logic               memWrite;
  } memStage_t;

  typedef struct packed {
    logic [`REG_AW-1:0] regRd;
    logic               regWrite;
    logic               memToReg;
    logic               hlt;
    logic               pcs;
  } wbStage_t;

  // Branch outcome and predictor update
  typedef struct packed {
    logic               actualTaken;
    logic               wenBht;        // Train direction table
    logic [`WORD_W-1:0] branchTarget;
    logic               wenBtb;        // Train target buffer
    logic [`WORD_W-1:0] actualTarget;  // Where fetch should be
  } branchRes_t;

endpackage

//--- hw/decodeIfs.sv
`timescale 1ns/1ps
`include "cpuDefs_defs.svh"

// Two read ports of the register file
interface regReadIf (
  input logic clk
);
  logic [`REG_AW-1:0] srcReg1;   // Port 1 address
  logic [`REG_AW-1:0] srcReg2;   // Port 2 address
  logic [`WORD_W-1:0] srcData1;  // Port 1 data
  logic [`WORD_W-1:0] srcData2;  // Port 2 data

  modport decoder (input clk, output srcReg1, srcReg2, input srcData1, srcData2);
  modport file (input clk, input srcReg1, srcReg2, output srcData1, srcData2);
endinterface

// Operands for the branch resolver and its result
interface branchIf;
  import isaPkg::*;
  import pipePkg::*;

  condCode_e          cond;
  logic [8:0]         offset;           // Word offset for B
  logic [`WORD_W-1:0] rsData;           // Target for BR
  logic               isBr;
  logic               branch;
  logic [2:0]         flags;            // Z V N
  logic [`WORD_W-1:0] predictedTarget;
  logic [`WORD_W-1:0] pcNext;
  branchRes_t         res;

  modport decoder (output cond, offset, rsData, isBr, branch, flags, predictedTarget, pcNext,
                   input res);
  modport resolver (input cond, offset, rsData, isBr, branch, flags, predictedTarget, pcNext,
                    output res);
endinterface

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  isaPkg::opcode_e    opcode,  // Bits 15:12
  output pipePkg::ctrlWord_t ctrl     // Decoded control fields
);
  import isaPkg::*;

  ////////////////////////////////////////
  // Opcode lookup
  ////////////////////////////////////////
  always_comb begin
    ctrl       = '0;      // Everything off unless the opcode sets it
    ctrl.aluOp = opcode;  // ALU decodes its own function
    unique case (opcode)
      ADD, SUB: begin
        ctrl.regWrite = 1'b1;
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1;  // Only arithmetic sets N and V
      end
      XOR: begin
        ctrl.regWrite = 1'b1;
        ctrl.zEn      = 1'b1;
      end
      RED, PADDSB: begin
        ctrl.regWrite = 1'b1;  // No flag update
      end
      SLL, SRA, ROR: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;  // Shift amount in the imm field
        ctrl.zEn      = 1'b1;
      end
      LW: begin
        ctrl.regWrite  = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.aluSrc    = 1'b1;  // Base plus offset
      end
      SW: begin
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrc    = 1'b1;
      end
      LLB, LHB: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;  // 8-bit immediate
        ctrl.regSrc   = 1'b1;  // Old rd value is merged
      end
      B, BR: begin
        ctrl.branch = 1'b1;    // Resolved here in decode
      end
      PCS: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcs      = 1'b1;  // Writes next PC to rd
      end
      HLT: begin
        ctrl.hlt = 1'b1;
      end
    endcase
  end

endmodule

//--- hw/branchControl.sv
`timescale 1ns/1ps
`include "cpuDefs_defs.svh"

module branchControl (
  branchIf.resolver br  // Operands in and result out
);
  import isaPkg::*;

  logic               condMet;     // Flags satisfy the condition
  logic               taken;       // Branch instruction and condition met
  logic [`WORD_W-1:0] offsetExt;   // Byte offset
  logic [`WORD_W-1:0] target;      // Where the branch goes if taken
  logic               zf;
  logic               vf;
  logic               nf;

  assign zf = br.flags[flagZ];
  assign vf = br.flags[flagV];
  assign nf = br.flags[flagN];

  ////////////////////////////////////////
  // Condition evaluation
  ////////////////////////////////////////
  always_comb begin
    unique case (br.cond)
      NEQ:     condMet = ~zf;
      EQ:      condMet = zf;
      GT:      condMet = ~zf & ~nf;
      LT:      condMet = nf;
      GTE:     condMet = zf | (~zf & ~nf);
      LTE:     condMet = nf | zf;
      OVFL:    condMet = vf;
      UNCOND:  condMet = 1'b1;
      default: condMet = 1'b0;  // Unreachable with a legal cond
    endcase
  end

  assign taken = br.branch & condMet;

  // Offset counts instructions so shift by one for bytes
  assign offsetExt = {{(`WORD_W - 10){br.offset[8]}}, br.offset, 1'b0};

  // BR jumps to rs and B is relative to the next PC
  assign target = br.isBr ? br.rsData : (br.pcNext + offsetExt);

  ////////////////////////////////////////
  // Result and predictor training
  ////////////////////////////////////////
  always_comb begin
    br.res.actualTaken  = taken;
    br.res.branchTarget = target;
    br.res.actualTarget = taken ? target : br.pcNext;  // Fall through when not taken
    br.res.wenBht       = br.branch;  // Every branch trains direction
    // Target buffer only learns when the guess was wrong
    br.res.wenBtb       = taken & (target != br.predictedTarget);
  end

endmodule

//--- hw/registerFile.sv
`timescale 1ns/1ps
`include "cpuDefs_defs.svh"

module registerFile (
  input logic               clk,
  input logic               rstN,
  regReadIf.file            rd,           // Two combinational read ports
  input logic               wbRegWrite,   // Write strobe from writeback
  input logic [`REG_AW-1:0] wbRegRd,
  input logic [`WORD_W-1:0] wbWriteData
);

  logic [`WORD_W-1:0] regs [`NUM_REGS];

  // One read port with register 0 forced low and write-through bypass
  function automatic logic [`WORD_W-1:0] readReg(input logic [`REG_AW-1:0] addr);
    if (addr == '0) return '0;
    if (wbRegWrite && (wbRegRd == addr)) return wbWriteData;  // Same cycle write
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wbRegWrite && (wbRegRd != '0)) begin  // Register 0 ignores writes
      regs[wbRegRd] <= wbWriteData;
    end
  end

  always_comb begin
    rd.srcData1 = readReg(rd.srcReg1);
    rd.srcData2 = readReg(rd.srcReg2);
  end

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/1ps
`include "cpuDefs_defs.svh"

module decodeStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic [`WORD_W-1:0]  pcCurr,           // PC fetched this cycle
  input  logic [`WORD_W-1:0]  pcInst,           // Instruction word
  input  logic [`WORD_W-1:0]  pcNext,           // Address after this instruction
  input  logic [2:0]          flags,            // Z V N
  input  logic [`WORD_W-1:0]  predictedTarget,  // Predictor guess for this instruction
  input  logic                wbRegWrite,
  input  logic [`REG_AW-1:0]  wbRegRd,
  input  logic [`WORD_W-1:0]  wbWriteData,
  output pipePkg::exStage_t   exSignals,
  output pipePkg::memStage_t  memSignals,
  output pipePkg::wbStage_t   wbSignals,
  output pipePkg::branchRes_t branchOut,
  output logic                updatePc          // Redirect fetch to actualTarget
);
  import isaPkg::*;
  import pipePkg::*;

  ctrlWord_t          ctrl;
  logic               isNop;     // All-zero word
  logic [`REG_AW-1:0] regRd;
  logic [`REG_AW-1:0] regRs;
  logic [`REG_AW-1:0] regRt;
  logic [`WORD_W-1:0] immExt;    // 4-bit field extended
  logic [`WORD_W-1:0] aluImm;

  regReadIf rdIf (.clk(clk));
  branchIf  brIf ();

  ////////////////////////////////////////
  // Fields and control
  ////////////////////////////////////////
  assign isNop = (pcInst == '0);
  assign regRd = pcInst[11:8];
  assign regRs = pcInst[7:4];
  assign regRt = pcInst[3:0];

  controlUnit iCtrl (
    .opcode (opcode_e'(pcInst[15:12])),
    .ctrl   (ctrl)
  );

  // LLB and LHB merge into rd so they read it
  assign rdIf.srcReg1 = ctrl.regSrc ? regRd : regRs;
  assign rdIf.srcReg2 = ctrl.memWrite ? regRd : regRt;  // SW stores rd

  registerFile iRegFile (
    .clk         (clk),
    .rstN        (rstN),
    .rd          (rdIf.file),
    .wbRegWrite  (wbRegWrite),
    .wbRegRd     (wbRegRd),
    .wbWriteData (wbWriteData)
  );

  // Memory offsets are signed
  assign immExt = ctrl.memEnable ? {{(`WORD_W - 4){pcInst[3]}}, pcInst[3:0]}
                                 : {{(`WORD_W - 4){1'b0}}, pcInst[3:0]};
  assign aluImm = ctrl.regSrc ? {{(`WORD_W - 8){1'b0}}, pcInst[7:0]} : immExt;

  ////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////
  assign brIf.cond            = condCode_e'(pcInst[11:9]);
  assign brIf.offset          = pcInst[8:0];
  assign brIf.rsData          = rdIf.srcData1;  // rs is port 1 for branches
  assign brIf.isBr            = pcInst[12];     // Splits BR from B
  assign brIf.branch          = ctrl.branch;
  assign brIf.flags           = flags;
  assign brIf.predictedTarget = predictedTarget;
  assign brIf.pcNext          = pcNext;

  branchControl iBranch (.br(brIf.resolver));

  assign branchOut = brIf.res;
  assign updatePc  = ctrl.branch & (pcCurr != brIf.res.actualTarget);  // Fetched the wrong PC

  // Bundles for later stages, zero for a NOP
  always_comb begin
    exSignals  = '0;
    memSignals = '0;
    wbSignals  = '0;
    if (!isNop) begin
      exSignals.srcReg1       = rdIf.srcReg1;
      exSignals.srcReg2       = rdIf.srcReg2;
      exSignals.aluIn1        = rdIf.srcData1;
      exSignals.aluImm        = aluImm;
      exSignals.aluIn2        = rdIf.srcData2;  // EX picks imm or reg by aluSrc
      exSignals.aluOp         = ctrl.aluOp;
      exSignals.aluSrc        = ctrl.aluSrc;
      exSignals.zEn           = ctrl.zEn;
      exSignals.nvEn          = ctrl.nvEn;
      memSignals.memWriteData = rdIf.srcData2;
      memSignals.memEnable    = ctrl.memEnable;
      memSignals.memWrite     = ctrl.memWrite;
      wbSignals.regRd         = regRd;
      wbSignals.regWrite      = ctrl.regWrite;
      wbSignals.memToReg      = ctrl.memToReg;
      wbSignals.hlt           = ctrl.hlt;
      wbSignals.pcs           = ctrl.pcs;
    end
  end

endmodule

//--- hw/decodeTop.sv
`timescale 1ns/1ps
`include "cpuDefs_defs.svh"

module decodeTop (
  input  logic                clk,
  input  logic                rstN,             // Clears the register file

  // Fetch side
  input  logic [`WORD_W-1:0]  pcCurr,
  input  logic [`WORD_W-1:0]  pcInst,
  input  logic [`WORD_W-1:0]  pcNext,
  input  logic [2:0]          flags,            // From the EX flag register
  input  logic [`WORD_W-1:0]  predictedTarget,

  // Writeback port
  input  logic                wbRegWrite,
  input  logic [`REG_AW-1:0]  wbRegRd,
  input  logic [`WORD_W-1:0]  wbWriteData,

  // To the ID/EX register
  output pipePkg::exStage_t   exSignals,
  output pipePkg::memStage_t  memSignals,
  output pipePkg::wbStage_t   wbSignals,

  // To fetch and the predictor
  output pipePkg::branchRes_t branchOut,
  output logic                updatePc
);

  ////////////////////////////////////////
  // Decode stage
  ////////////////////////////////////////
  decodeStage iStage (
    .clk             (clk),
    .rstN            (rstN),
    .pcCurr          (pcCurr),
    .pcInst          (pcInst),
    .pcNext          (pcNext),
    .flags           (flags),
    .predictedTarget (predictedTarget),
    .wbRegWrite      (wbRegWrite),
    .wbRegRd         (wbRegRd),
    .wbWriteData     (wbWriteData),
    .exSignals       (exSignals),
    .memSignals      (memSignals),
    .wbSignals       (wbSignals),
    .branchOut       (branchOut),
    .updatePc        (updatePc)
  );

endmodule

//--- tests/decodeTb.sv
`timescale 1ns/1ps
`include "cpuDefs_defs.svh"

module decodeTb;
  import isaPkg::*;
  import pipePkg::*;

  localparam int resetCycles  = 5;
  localparam int numRandom    = 2000;
  localparam int testCycles   = resetCycles + 1 + `NUM_REGS + numRandom;  // Reset, sweep, random
  localparam int timeoutLimit = testCycles + 50;

  logic               clk;
  logic               rstN;
  logic [`WORD_W-1:0] pcCurr;
  logic [`WORD_W-1:0] pcInst;
  logic [`WORD_W-1:0] pcNext;
  logic [2:0]         flags;            // Z V N
  logic [`WORD_W-1:0] predictedTarget;
  logic               wbRegWrite;
  logic [`REG_AW-1:0] wbRegRd;
  logic [`WORD_W-1:0] wbWriteData;
  exStage_t           exSignals;
  memStage_t          memSignals;
  wbStage_t           wbSignals;
  branchRes_t         branchOut;
  logic               updatePc;

  // Reference model state
  logic [`WORD_W-1:0] modelRegs [`NUM_REGS];
  exStage_t           expEx;
  memStage_t          expMem;
  wbStage_t           expWb;
  branchRes_t         expBr;
  logic               expUpd;
  logic [31:0]        lcgState = 32'h55722a7a;
  int                 cycleCount = 0;

  decodeTop UUT (
    .clk             (clk),
    .rstN            (rstN),
    .pcCurr          (pcCurr),
    .pcInst          (pcInst),
    .pcNext          (pcNext),
    .flags           (flags),
    .predictedTarget (predictedTarget),
    .wbRegWrite      (wbRegWrite),
    .wbRegRd         (wbRegRd),
    .wbWriteData     (wbWriteData),
    .exSignals       (exSignals),
    .memSignals      (memSignals),
    .wbSignals       (wbSignals),
    .branchOut       (branchOut),
    .updatePc        (updatePc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Run guard
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout: no end of test after %0d cycles", cycleCount);
      $display("test failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////
  // Random numbers and checks
  ////////////////////////////////////////
  function automatic logic [15:0] randWord();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];  // High bits have the longer period
  endfunction

  task automatic reportMismatch(input string field, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("** Error at %0t ns: %s is %h, expected %h", $time, field, got, exp);
    $display("test failed");
    $fatal(1, "Mismatch on %s", field);
  endtask

  task automatic checkEx(input exStage_t got, input exStage_t exp);
    if (got.srcReg1 !== exp.srcReg1) reportMismatch("ex.srcReg1", got.srcReg1, exp.srcReg1);
    if (got.srcReg2 !== exp.srcReg2) reportMismatch("ex.srcReg2", got.srcReg2, exp.srcReg2);
    if (got.aluIn1 !== exp.aluIn1) reportMismatch("ex.aluIn1", got.aluIn1, exp.aluIn1);
    if (got.aluImm !== exp.aluImm) reportMismatch("ex.aluImm", got.aluImm, exp.aluImm);
    if (got.aluIn2 !== exp.aluIn2) reportMismatch("ex.aluIn2", got.aluIn2, exp.aluIn2);
    if (got.aluOp !== exp.aluOp) reportMismatch("ex.aluOp", got.aluOp, exp.aluOp);
    if (got.aluSrc !== exp.aluSrc) reportMismatch("ex.aluSrc", got.aluSrc, exp.aluSrc);
    if (got.zEn !== exp.zEn) reportMismatch("ex.zEn", got.zEn, exp.zEn);
    if (got.nvEn !== exp.nvEn) reportMismatch("ex.nvEn", got.nvEn, exp.nvEn);
  endtask

  task automatic checkMem(input memStage_t got, input memStage_t exp);
    if (got.memWriteData !== exp.memWriteData)
      reportMismatch("mem.memWriteData", got.memWriteData, exp.memWriteData);
    if (got.memEnable !== exp.memEnable)
      reportMismatch("mem.memEnable", got.memEnable, exp.memEnable);
    if (got.memWrite !== exp.memWrite) reportMismatch("mem.memWrite", got.memWrite, exp.memWrite);
  endtask

  task automatic checkWb(input wbStage_t got, input wbStage_t exp);
    if (got.regRd !== exp.regRd) reportMismatch("wb.regRd", got.regRd, exp.regRd);
    if (got.regWrite !== exp.regWrite) reportMismatch("wb.regWrite", got.regWrite, exp.regWrite);
    if (got.memToReg !== exp.memToReg) reportMismatch("wb.memToReg", got.memToReg, exp.memToReg);
    if (got.hlt !== exp.hlt) reportMismatch("wb.hlt", got.hlt, exp.hlt);
    if (got.pcs !== exp.pcs) reportMismatch("wb.pcs", got.pcs, exp.pcs);
  endtask

  task automatic checkBranch(input branchRes_t got, input branchRes_t exp);
    if (got.actualTaken !== exp.actualTaken)
      reportMismatch("br.actualTaken", got.actualTaken, exp.actualTaken);
    if (got.wenBht !== exp.wenBht) reportMismatch("br.wenBht", got.wenBht, exp.wenBht);
    if (got.branchTarget !== exp.branchTarget)
      reportMismatch("br.branchTarget", got.branchTarget, exp.branchTarget);
    if (got.wenBtb !== exp.wenBtb) reportMismatch("br.wenBtb", got.wenBtb, exp.wenBtb);
    if (got.actualTarget !== exp.actualTarget)
      reportMismatch("br.actualTarget", got.actualTarget, exp.actualTarget);
  endtask

  task automatic checkBit(input logic got, input logic exp, input string name);
    if (got !== exp) reportMismatch(name, got, exp);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Register read as seen in the current cycle
  function automatic logic [`WORD_W-1:0] readModel(input logic [`REG_AW-1:0] addr);
    if (addr == 0) return '0;                                 // Zero register
    if (wbRegWrite && (wbRegRd == addr)) return wbWriteData;  // Write-through
    return modelRegs[addr];
  endfunction

  function automatic logic condHolds(input logic [2:0] cc, input logic [2:0] f);
    logic z;
    logic v;
    logic n;
    z = f[flagZ];
    v = f[flagV];
    n = f[flagN];
    case (cc)
      NEQ:     return !z;
      EQ:      return z;
      GT:      return !z && !n;
      LT:      return n;
      GTE:     return z || (!z && !n);
      LTE:     return n || z;
      OVFL:    return v;
      default: return 1'b1;  // UNCOND
    endcase
  endfunction

  task automatic predict();
    logic [3:0]         op;
    logic [`REG_AW-1:0] rdA;
    logic [`REG_AW-1:0] src1;
    logic [`REG_AW-1:0] src2;
    logic [`WORD_W-1:0] data1;
    logic [`WORD_W-1:0] data2;
    logic [`WORD_W-1:0] imm;
    logic [`WORD_W-1:0] target;
    logic               isMem;
    logic               isByte;
    logic               isShift;
    logic               br;
    logic               taken;
    op      = pcInst[15:12];
    rdA     = pcInst[11:8];
    isMem   = (op == LW) || (op == SW);
    isByte  = (op == LLB) || (op == LHB);
    isShift = (op == SLL) || (op == SRA) || (op == ROR);
    br      = (op == B) || (op == BR);
    src1    = isByte ? rdA : pcInst[7:4];       // Byte loads merge into rd
    src2    = (op == SW) ? rdA : pcInst[3:0];   // Store data comes from rd
    data1   = readModel(src1);
    data2   = readModel(src2);
    if (isByte) imm = {8'h00, pcInst[7:0]};
    else if (isMem) imm = {{12{pcInst[3]}}, pcInst[3:0]};  // Signed offset
    else imm = {12'h000, pcInst[3:0]};
    expEx  = '0;
    expMem = '0;
    expWb  = '0;
    if (pcInst != 0) begin  // NOP leaves the bundles at zero
      expEx.srcReg1       = src1;
      expEx.srcReg2       = src2;
      expEx.aluIn1        = data1;
      expEx.aluImm        = imm;
      expEx.aluIn2        = data2;
      expEx.aluOp         = opcode_e'(op);
      expEx.aluSrc        = isShift || isMem || isByte;
      expEx.zEn           = (op == ADD) || (op == SUB) || (op == XOR) || isShift;
      expEx.nvEn          = (op == ADD) || (op == SUB);
      expMem.memWriteData = data2;
      expMem.memEnable    = isMem;
      expMem.memWrite     = (op == SW);
      expWb.regRd         = rdA;
      expWb.regWrite      = (op <= 4'h7) || (op == LW) || isByte || (op == PCS);
      expWb.memToReg      = (op == LW);
      expWb.hlt           = (op == HLT);
      expWb.pcs           = (op == PCS);
    end
    // Bit 12 picks register target over PC relative
    target = pcInst[12] ? data1 : pcNext + {{6{pcInst[8]}}, pcInst[8:0], 1'b0};
    taken  = br && condHolds(pcInst[11:9], flags);
    expBr.actualTaken  = taken;
    expBr.wenBht       = br;
    expBr.branchTarget = target;
    expBr.actualTarget = taken ? target : pcNext;
    expBr.wenBtb       = taken && (target != predictedTarget);
    expUpd             = br && (pcCurr != expBr.actualTarget);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic runCycle(input logic [`WORD_W-1:0] inst, input logic wbWe,
                          input logic [`REG_AW-1:0] wbAddr, input logic [`WORD_W-1:0] wbData);
    logic [15:0] r;
    @(posedge clk);
    #1;
    pcInst          = inst;
    wbRegWrite      = wbWe;
    wbRegRd         = wbAddr;
    wbWriteData     = wbData;
    pcNext          = randWord();
    r               = randWord();
    flags           = r[2:0];
    predictedTarget = randWord();
    pcCurr          = randWord();
    predict();
    r = randWord();
    if (r[0]) predictedTarget = expBr.branchTarget;  // Predictor guessed the target
    if (r[1]) pcCurr = expBr.actualTarget;            // Fetch already on the right path
    predict();
    #8;  // Just before the next edge
    checkEx(exSignals, expEx);
    checkMem(memSignals, expMem);
    checkWb(wbSignals, expWb);
    checkBranch(branchOut, expBr);
    checkBit(updatePc, expUpd, "updatePc");
    if (wbWe && (wbAddr != 0)) modelRegs[wbAddr] = wbData;  // Lands on this edge
  endtask

  initial begin
    int          i;
    logic [15:0] ctl;
    logic [15:0] inst;
    logic [15:0] addr;
    rstN            = 1'b0;
    pcCurr          = '0;
    pcInst          = '0;
    pcNext          = '0;
    flags           = '0;
    predictedTarget = '0;
    wbRegWrite      = 1'b0;
    wbRegRd         = '0;
    wbWriteData     = '0;
    for (i = 0; i < `NUM_REGS; i++) begin
      modelRegs[i] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    #8;
    // Zero word after reset gives an idle stage
    checkEx(exSignals, '0);
    checkMem(memSignals, '0);
    checkWb(wbSignals, '0);
    checkBranch(branchOut, '0);
    checkBit(updatePc, 1'b0, "updatePc");
    // Every register reads back zero
    for (i = 0; i < `NUM_REGS; i++) begin
      runCycle({ADD, 4'h1, 4'(i), 4'(i)}, 1'b0, '0, '0);
    end
    for (i = 0; i < numRandom; i++) begin
      ctl  = randWord();
      inst = randWord();
      addr = randWord();
      if (ctl[4:0] == 0) inst = '0;  // Occasional NOP
      runCycle(inst, ctl[5], addr[3:0], randWord());
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- build.f
+incdir+hw
hw/isaPkg.sv
hw/pipePkg.sv
hw/decodeIfs.sv
hw/controlUnit.sv
hw/branchControl.sv
hw/registerFile.sv
hw/decodeStage.sv
hw/decodeTop.sv
tests/decodeTb.sv
